// File: tb.f
+incdir+include
design/cpuPkg.sv
design/regFile.sv
design/alu.sv
design/memoryUnit.sv
design/conFf.sv
design/datapath.sv
verification/datapathTb.sv

// File: include/tbSteps.svh
// Stimulus table, one control word per step, built at time zero
// Needs cpuPkg, seed and aluRef in the including module
`ifndef TB_STEPS_SVH
`define TB_STEPS_SVH

typedef struct {
    ctrlWord              ctrl;
    logic [dataWidth-1:0] inData;
    bit                   check;
    logic [dataWidth-1:0] expOut;
    logic                 expCon;
} stepRec;

localparam int raLsb = raMsb - regIdxWidth + 1;
localparam int rbLsb = rbMsb - regIdxWidth + 1;
localparam int rcLsb = rcMsb - regIdxWidth + 1;

stepRec               steps[$];
logic [dataWidth-1:0] curOut;
logic                 curCon;

function automatic ctrlWord idle();
    ctrlWord c;
    c = '0;
    return c;
endfunction

task automatic addRow(ctrlWord c, logic [dataWidth-1:0] inData, bit check);
    steps.push_back('{c, inData, check, curOut, curCon});
endtask

// IR is loaded by way of the in-port
task automatic setIr(logic [dataWidth-1:0] word);
    ctrlWord c;
    c = idle();
    c.inPortIn = 1'b1;
    addRow(c, word, 1'b0);
    c = idle();
    c.src = srcInPort;
    c.irIn = 1'b1;
    addRow(c, '0, 1'b0);
endtask

task automatic loadReg(int idx, logic [dataWidth-1:0] val);
    ctrlWord c;
    setIr(idx << raLsb);
    c = idle();
    c.inPortIn = 1'b1;
    addRow(c, val, 1'b0);
    c = idle();
    c.src = srcInPort;
    c.field = fieldRa;
    c.rIn = 1'b1;
    addRow(c, '0, 1'b0);
endtask

task automatic outBus(busSrc s, regField f, logic [dataWidth-1:0] expVal);
    ctrlWord c;
    c = idle();
    c.src = s;
    c.field = f;
    c.outPortIn = 1'b1;
    curOut = expVal;
    addRow(c, '0, 1'b1);
endtask

task automatic busRow(busSrc s, regField f, ctrlWord c);
    c.src = s;
    c.field = f;
    addRow(c, '0, 1'b0);
endtask

task automatic memWrite(int addr, logic [dataWidth-1:0] val);
    ctrlWord c;
    c = idle();
    c.inPortIn = 1'b1;
    addRow(c, addr, 1'b0);
    c = idle();
    c.marIn = 1'b1;
    busRow(srcInPort, fieldNone, c);
    c = idle();
    c.inPortIn = 1'b1;
    addRow(c, val, 1'b0);
    c = idle();
    c.mdrIn = 1'b1;
    busRow(srcInPort, fieldNone, c);
    c = idle();
    c.write = 1'b1;
    addRow(c, '0, 1'b0);
endtask

task automatic memRead(int addr, logic [dataWidth-1:0] expVal);
    ctrlWord c;
    c = idle();
    c.inPortIn = 1'b1;
    addRow(c, addr, 1'b0);
    c = idle();
    c.marIn = 1'b1;
    busRow(srcInPort, fieldNone, c);
    c = idle();
    c.read = 1'b1;
    c.mdrIn = 1'b1;
    addRow(c, '0, 1'b0);
    outBus(srcMdr, fieldNone, expVal);
endtask

// Y from Ra, Z from op on Rb, result into Rc and out
task automatic aluTwo(aluOp op);
    logic [dataWidth-1:0]   a;
    logic [dataWidth-1:0]   b;
    logic [2*dataWidth-1:0] r;
    ctrlWord                c;
    a = $random(seed);
    b = $random(seed);
    r = aluRef(op, a, b);
    loadReg(1, a);
    loadReg(2, b);
    setIr((1 << raLsb) | (2 << rbLsb) | (3 << rcLsb));
    c = idle();
    c.yIn = 1'b1;
    busRow(srcReg, fieldRa, c);
    c = idle();
    c.zIn = 1'b1;
    c.op = op;
    busRow(srcReg, fieldRb, c);
    c = idle();
    c.rIn = 1'b1;
    busRow(srcZLow, fieldRc, c);
    outBus(srcReg, fieldRc, r[dataWidth-1:0]);
endtask

task automatic aluOne(aluOp op);
    logic [dataWidth-1:0]   b;
    logic [2*dataWidth-1:0] r;
    ctrlWord                c;
    b = $random(seed);
    r = aluRef(op, '0, b);
    loadReg(2, b);
    setIr(2 << rbLsb);
    c = idle();
    c.zIn = 1'b1;
    c.op = op;
    busRow(srcReg, fieldRb, c);
    outBus(srcZLow, fieldNone, r[dataWidth-1:0]);
endtask

// Result split into HI and LO, both shown on the out-port
task automatic aluWide(aluOp op, logic [dataWidth-1:0] a, logic [dataWidth-1:0] b);
    logic [2*dataWidth-1:0] r;
    ctrlWord                c;
    r = aluRef(op, a, b);
    loadReg(1, a);
    loadReg(2, b);
    setIr((1 << raLsb) | (2 << rbLsb));
    c = idle();
    c.yIn = 1'b1;
    busRow(srcReg, fieldRa, c);
    c = idle();
    c.zIn = 1'b1;
    c.op = op;
    busRow(srcReg, fieldRb, c);
    c = idle();
    c.hiIn = 1'b1;
    busRow(srcZHigh, fieldNone, c);
    c = idle();
    c.loIn = 1'b1;
    busRow(srcZLow, fieldNone, c);
    outBus(srcHi, fieldNone, r[2*dataWidth-1:dataWidth]);
    outBus(srcLo, fieldNone, r[dataWidth-1:0]);
endtask

task automatic condCheck(int idx, logic [dataWidth-1:0] val, condCode cc);
    ctrlWord c;
    setIr((idx << raLsb) | (int'(cc) << (condMsb - 1)));
    case (cc)
        condZero:     curCon = (val == 0);
        condNonZero:  curCon = (val != 0);
        condPositive: curCon = !val[dataWidth-1] && (val != 0);
        default:      curCon = val[dataWidth-1];
    endcase
    c = idle();
    c.src = srcReg;
    c.field = fieldRa;
    c.conIn = 1'b1;
    addRow(c, '0, 1'b1);
endtask

`endif

// File: verification/datapathTb.sv
// Table-driven testbench driving one control word per cycle on the falling edge
// Stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module datapathTb import cpuPkg::*; ();

    logic                 clk;
    logic                 arstN;
    ctrlWord              ctrl;
    logic [dataWidth-1:0] inPortData;
    logic [dataWidth-1:0] outPortData;
    logic                 con;
    int                   seed;
    int                   cycleCount;
    int                   cycleLimit;

    // Reference model of the ALU rules
    function automatic logic [2*dataWidth-1:0] aluRef(aluOp op, logic [dataWidth-1:0] y,
                                                      logic [dataWidth-1:0] b);
        logic [4:0]           n;
        logic [dataWidth-1:0] lowWord;
        n = b[4:0];
        lowWord = '0;
        case (op)
            aluAdd:  lowWord = y + b;
            aluSub:  lowWord = y - b;
            aluMul:  return $signed({{dataWidth{y[31]}}, y}) * $signed({{dataWidth{b[31]}}, b});
            aluDiv: begin
                if (b == 0) begin
                    return '0;
                end
                return {$signed(y) % $signed(b), $signed(y) / $signed(b)};
            end
            aluShr:  lowWord = y >> n;
            aluShl:  lowWord = y << n;
            aluShra: lowWord = $signed(y) >>> n;
            aluRor:  lowWord = (y >> n) | (y << (dataWidth - n));
            aluRol:  lowWord = (y << n) | (y >> (dataWidth - n));
            aluAnd:  lowWord = y & b;
            aluOr:   lowWord = y | b;
            aluNeg:  lowWord = 0 - b;
            aluXor:  lowWord = y ^ b;
            aluNor:  lowWord = ~(y | b);
            aluNot:  lowWord = ~b;
            default: lowWord = '0;
        endcase
        return {{dataWidth{1'b0}}, lowWord};
    endfunction

    `include "tbSteps.svh"

    datapath datapath_i (
        .clk         (clk),
        .arstN       (arstN),
        .ctrl        (ctrl),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .con         (con)
    );

    always #4 clk = ~clk;

    task automatic checkData(string name, logic [dataWidth-1:0] got,
                             logic [dataWidth-1:0] expVal);
        if (got !== expVal) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expVal);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic checkCon(string name, logic got, logic expVal);
        if (got !== expVal) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expVal);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic compareRow(int idx);
        checkData("outPortData", outPortData, steps[idx].expOut);
        checkCon("con", con, steps[idx].expCon);
    endtask

    task automatic buildTable();
        aluOp                 twoOps[10];
        logic [dataWidth-1:0] v;
        logic [dataWidth-1:0] w;
        ctrlWord              c;
        twoOps = '{aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
                   aluShr, aluShl, aluShra, aluRor};
        curOut = '0;
        curCon = 1'b0;
        addRow(idle(), '0, 1'b1);
        v = $random(seed);
        loadReg(5, v);
        outBus(srcReg, fieldRa, v);
        foreach (twoOps[i]) begin
            aluTwo(twoOps[i]);
        end
        aluTwo(aluRol);
        aluOne(aluNeg);
        aluOne(aluNot);
        aluWide(aluMul, $random(seed), $random(seed));
        aluWide(aluDiv, $random(seed), $random(seed) & 32'hffff);
        aluWide(aluDiv, $random(seed), '0);
        v = $random(seed);
        w = $random(seed);
        memWrite(7, v);
        memWrite(12, w);
        memRead(7, v);
        memRead(12, w);
        // Fetch of jr R2 from address 0
        // MAR, MDR and IR start out holding other values so only the fetch can set them
        memWrite(0, 32'hA1000000);
        memWrite(1, 0);
        loadReg(2, 10);
        setIr(0);
        c = idle();
        c.marIn = 1'b1;
        c.incPc = 1'b1;
        c.zIn = 1'b1;
        busRow(srcPc, fieldNone, c);
        c = idle();
        c.pcIn = 1'b1;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        busRow(srcZLow, fieldNone, c);
        c = idle();
        c.irIn = 1'b1;
        busRow(srcMdr, fieldNone, c);
        outBus(srcPc, fieldNone, 1);
        c = idle();
        c.pcIn = 1'b1;
        busRow(srcReg, fieldRa, c);
        outBus(srcPc, fieldNone, 10);
        v = ($random(seed) & 32'h7fffffff) | 1;
        w = $random(seed) | 32'h80000000;
        loadReg(4, 0);
        loadReg(5, v);
        loadReg(6, w);
        for (int cc = 0; cc < 4; cc++) begin
            condCheck(4, 0, condCode'(cc));
            condCheck(5, v, condCode'(cc));
            condCheck(6, w, condCode'(cc));
        end
        // R0 reads as zero only under base-address selection
        loadReg(0, v);
        outBus(srcReg, fieldRa, v);
        c = idle();
        c.src = srcReg;
        c.field = fieldRa;
        c.baOut = 1'b1;
        c.outPortIn = 1'b1;
        curOut = '0;
        addRow(c, '0, 1'b1);
        // Constant field with bit 18 set is sign-extended
        setIr(32'h0007fffb);
        outBus(srcConst, fieldNone, 32'hfffffffb);
        outBus(srcNone, fieldNone, '0);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the step table did not finish in %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1);
        end
    end

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        ctrl = '0;
        inPortData = '0;
        cycleCount = 0;
        cycleLimit = 100000;
        seed = 32'he70a3c5c;
        buildTable();
        cycleLimit = steps.size() + 2 + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            if (i > 0 && steps[i-1].check) begin
                compareRow(i - 1);
            end
            ctrl = steps[i].ctrl;
            inPortData = steps[i].inData;
        end
        @(negedge clk);
        if (steps[steps.size()-1].check) begin
            compareRow(steps.size() - 1);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/datapath.sv
// Single-bus datapath top, one control word is applied every clock cycle
// Exactly one source drives the bus, srcNone gives zero
// No instruction decode here, control words come from outside
`timescale 1ns/1ps
`default_nettype none

module datapath import cpuPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire ctrlWord              ctrl,
    input  wire logic [dataWidth-1:0] inPortData,
    output logic      [dataWidth-1:0] outPortData,
    output logic                      con
);

    logic [dataWidth-1:0]   bus;
    logic [dataWidth-1:0]   pc;
    logic [dataWidth-1:0]   ir;
    logic [dataWidth-1:0]   y;
    logic [2*dataWidth-1:0] z;
    logic [dataWidth-1:0]   hi;
    logic [dataWidth-1:0]   lo;
    logic [dataWidth-1:0]   inPort;
    logic [dataWidth-1:0]   regOut;
    logic [dataWidth-1:0]   mdr;
    logic [2*dataWidth-1:0] aluResult;
    logic [dataWidth-1:0]   constExt;

    // Sign-extended immediate from IR
    assign constExt = {{(dataWidth-constWidth){ir[constWidth-1]}}, ir[constWidth-1:0]};

    always_comb begin
        case (ctrl.src)
            srcReg:    bus = regOut;
            srcHi:     bus = hi;
            srcLo:     bus = lo;
            srcZHigh:  bus = z[2*dataWidth-1:dataWidth];
            srcZLow:   bus = z[dataWidth-1:0];
            srcPc:     bus = pc;
            srcMdr:    bus = mdr;
            srcInPort: bus = inPort;
            srcConst:  bus = constExt;
            default:   bus = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ir <= '0;
            y <= '0;
            z <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
            if (ctrl.yIn) begin
                y <= bus;
            end
            // Z sees Y and the bus of the same step
            if (ctrl.zIn) begin
                z <= aluResult;
            end
            if (ctrl.hiIn) begin
                hi <= bus;
            end
            if (ctrl.loIn) begin
                lo <= bus;
            end
        end
    end

    // Port registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inPort <= '0;
            outPortData <= '0;
        end else begin
            if (ctrl.inPortIn) begin
                inPort <= inPortData;
            end
            if (ctrl.outPortIn) begin
                outPortData <= bus;
            end
        end
    end

    regFile regFile_i (
        .clk    (clk),
        .arstN  (arstN),
        .ir     (ir),
        .field  (ctrl.field),
        .baOut  (ctrl.baOut),
        .rIn    (ctrl.rIn),
        .busIn  (bus),
        .regOut (regOut)
    );

    alu alu_i (
        .y      (y),
        .busIn  (bus),
        .op     (ctrl.op),
        .incPc  (ctrl.incPc),
        .result (aluResult)
    );

    memoryUnit memoryUnit_i (
        .clk   (clk),
        .arstN (arstN),
        .busIn (bus),
        .read  (ctrl.read),
        .write (ctrl.write),
        .marIn (ctrl.marIn),
        .mdrIn (ctrl.mdrIn),
        .mdr   (mdr)
    );

    conFf conFf_i (
        .clk   (clk),
        .arstN (arstN),
        .ir    (ir),
        .busIn (bus),
        .conIn (ctrl.conIn),
        .con   (con)
    );

endmodule

`default_nettype wire

// File: design/conFf.sv
// Branch condition flip-flop, the condition comes from the Rb field of IR
// Positive means sign clear and nonzero
`timescale 1ns/1ps
`default_nettype none

module conFf import cpuPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic [dataWidth-1:0] ir,
    input  wire logic [dataWidth-1:0] busIn,
    input  wire logic                 conIn,
    output logic                      con
);

    condCode cond;
    logic    isZero;
    logic    isNeg;
    logic    condMet;

    assign cond = condCode'(ir[condMsb -: 2]);
    assign isZero = (busIn == '0);
    assign isNeg = busIn[dataWidth-1];

    always_comb begin
        case (cond)
            condZero:     condMet = isZero;
            condNonZero:  condMet = !isZero;
            condPositive: condMet = !isNeg && !isZero;
            condNegative: condMet = isNeg;
            default:      condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            con <= 1'b0;
        end else if (conIn) begin
            con <= condMet;
        end
    end

endmodule

`default_nettype wire

// File: design/memoryUnit.sv
// MAR, MDR and a 512-word memory, read is asynchronous and write is clocked
// Memory content is undefined after reset, it is filled through MDR
`timescale 1ns/1ps
`default_nettype none

module memoryUnit import cpuPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic [dataWidth-1:0] busIn,
    input  wire logic                 read,
    input  wire logic                 write,
    input  wire logic                 marIn,
    input  wire logic                 mdrIn,
    output logic      [dataWidth-1:0] mdr
);

    logic [dataWidth-1:0]    mem [memWords];
    logic [memAddrWidth-1:0] mar;
    logic [dataWidth-1:0]    memWord;
    logic [dataWidth-1:0]    mdrNext;

    // Only the low address bits reach MAR
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= busIn[memAddrWidth-1:0];
        end
    end

    assign memWord = mem[mar];

    // MDR takes the memory word on a read, the bus otherwise
    assign mdrNext = read ? memWord : busIn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdr <= '0;
        end else if (mdrIn) begin
            mdr <= mdrNext;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[mar] <= mdr;
        end
    end

endmodule

`default_nettype wire

// File: design/alu.sv
// Combinational ALU, Y is the first operand and the bus the second
// incPc overrides the operation and returns bus plus one
// Division by zero gives zero quotient and zero remainder
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
    input  wire logic [dataWidth-1:0]   y,
    input  wire logic [dataWidth-1:0]   busIn,
    input  wire aluOp                   op,
    input  wire logic                   incPc,
    output logic      [2*dataWidth-1:0] result
);

    logic signed [dataWidth-1:0]   ySigned;
    logic signed [dataWidth-1:0]   busSigned;
    logic signed [2*dataWidth-1:0] product;
    logic signed [dataWidth-1:0]   quotient;
    logic signed [dataWidth-1:0]   remainder;
    logic        [4:0]             shamt;
    logic        [2*dataWidth-1:0] doubled;
    logic        [2*dataWidth-1:0] rorWide;
    logic        [2*dataWidth-1:0] rolWide;
    logic                          divByZero;

    assign ySigned = y;
    assign busSigned = busIn;
    assign shamt = busIn[4:0];

    assign product = ySigned * busSigned;

    assign divByZero = (busIn == '0);
    assign quotient = divByZero ? '0 : ySigned / busSigned;
    assign remainder = divByZero ? '0 : ySigned % busSigned;

    // Rotates work on Y placed twice side by side
    assign doubled = {y, y};
    assign rorWide = doubled >> shamt;
    assign rolWide = doubled << shamt;

    always_comb begin
        result = '0;
        if (incPc) begin
            result[dataWidth-1:0] = busIn + 1'b1;
        end else begin
            case (op)
                aluAdd: begin
                    result[dataWidth-1:0] = y + busIn;
                end
                aluSub: begin
                    result[dataWidth-1:0] = y - busIn;
                end
                aluMul: begin
                    result = product;
                end
                aluDiv: begin
                    // Remainder high, quotient low
                    result = {remainder, quotient};
                end
                aluShr: begin
                    result[dataWidth-1:0] = y >> shamt;
                end
                aluShl: begin
                    result[dataWidth-1:0] = y << shamt;
                end
                aluShra: begin
                    result[dataWidth-1:0] = ySigned >>> shamt;
                end
                aluRor: begin
                    result[dataWidth-1:0] = rorWide[dataWidth-1:0];
                end
                aluRol: begin
                    result[dataWidth-1:0] = rolWide[2*dataWidth-1:dataWidth];
                end
                aluAnd: begin
                    result[dataWidth-1:0] = y & busIn;
                end
                aluOr: begin
                    result[dataWidth-1:0] = y | busIn;
                end
                aluNeg: begin
                    result[dataWidth-1:0] = -busIn;
                end
                aluXor: begin
                    result[dataWidth-1:0] = y ^ busIn;
                end
                aluNor: begin
                    result[dataWidth-1:0] = ~(y | busIn);
                end
                aluNot: begin
                    result[dataWidth-1:0] = ~busIn;
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
// Sixteen general registers addressed through the IR fields
// R0 reads as zero only while baOut is set, otherwise it is an ordinary register
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic [dataWidth-1:0] ir,
    input  wire regField              field,
    input  wire logic                 baOut,
    input  wire logic                 rIn,
    input  wire logic [dataWidth-1:0] busIn,
    output logic      [dataWidth-1:0] regOut
);

    logic [dataWidth-1:0]   regs [regCount];
    logic [regIdxWidth-1:0] idx;
    logic                   regWrite;

    // Select the register index from the named IR field
    always_comb begin
        case (field)
            fieldRa: idx = ir[raMsb -: regIdxWidth];
            fieldRb: idx = ir[rbMsb -: regIdxWidth];
            fieldRc: idx = ir[rcMsb -: regIdxWidth];
            default: idx = '0;
        endcase
    end

    // No field selected means no register is written
    assign regWrite = rIn && (field != fieldNone);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[idx] <= busIn;
        end
    end

    // Base-address rule for R0
    always_comb begin
        if (baOut && (idx == '0)) begin
            regOut = '0;
        end else begin
            regOut = regs[idx];
        end
    end

endmodule

`default_nettype wire

// File: design/cpuPkg.sv
// Shared widths, instruction fields and control word for the single-bus datapath
// Field positions assume the fixed 32-bit instruction format with a 5-bit opcode
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = 4;
    localparam int memWords = 512;
    localparam int memAddrWidth = 9;

    // Instruction layout: op | Ra | Rb | Rc, or op | Ra | Rb | constant
    localparam int opMsb = 31;
    localparam int opWidth = 5;
    localparam int raMsb = opMsb - opWidth;
    localparam int rbMsb = raMsb - regIdxWidth;
    localparam int rcMsb = rbMsb - regIdxWidth;
    localparam int constWidth = 19;
    // Branch condition sits in the low two bits of the Rb field
    localparam int condMsb = rbMsb - 2;

    typedef enum logic [4:0] {
        aluNop, aluAdd, aluSub, aluMul,
        aluDiv, aluShr, aluShl, aluShra,
        aluRor, aluRol, aluAnd, aluOr,
        aluNeg, aluXor, aluNor, aluNot
    } aluOp;

    typedef enum logic [3:0] {
        srcNone, srcReg, srcHi, srcLo, srcZHigh,
        srcZLow, srcPc, srcMdr, srcInPort, srcConst
    } busSrc;

    typedef enum logic [1:0] {
        fieldNone, fieldRa, fieldRb, fieldRc
    } regField;

    typedef enum logic [1:0] {
        condZero, condNonZero, condPositive, condNegative
    } condCode;

    typedef struct packed {
        logic    read;
        logic    write;
        busSrc   src;
        regField field;
        logic    baOut;
        logic    rIn;
        logic    marIn;
        logic    mdrIn;
        logic    hiIn;
        logic    loIn;
        logic    yIn;
        logic    zIn;
        logic    pcIn;
        logic    irIn;
        logic    incPc;
        logic    inPortIn;
        logic    outPortIn;
        logic    conIn;
        aluOp    op;
    } ctrlWord;

endpackage

`default_nettype wire
